/* source/audio_pkg.sv */
// Audio sample types
`default_nettype none

package audio_pkg;

	//////////////////////////////////////////////////////////////////////
	// Samples
	//////////////////////////////////////////////////////////////////////

	typedef logic signed [15:0] sample_t;

	// One extra bit so a two-source sum can still be clamped
	typedef logic signed [16:0] wide_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// Speaker weight at volume 0 is 2**11
	localparam int SPK_BASE_SHIFT = 11;

	//////////////////////////////////////////////////////////////////////
	// Compressor curves
	//////////////////////////////////////////////////////////////////////

	// 2x curve
	localparam logic [15:0] CMP1_KNEE = 16'd14044;
	localparam logic [15:0] CMP1_GAIN = 16'd2;
	localparam logic [15:0] CMP1_FALL = 16'd4;
	localparam logic [15:0] CMP1_BASE = 16'd28088;

	// 4x curve with a harder knee
	localparam logic [15:0] CMP2_KNEE = 16'd7400;
	localparam logic [15:0] CMP2_GAIN = 16'd4;
	localparam logic [15:0] CMP2_FALL = 16'd8;
	localparam logic [15:0] CMP2_BASE = 16'd29600;

endpackage

`default_nettype wire

/* source/ctrl_pkg.sv */
// Control bus and register map
`default_nettype none

package ctrl_pkg;

	localparam int WB_REQ_ADR_W = 4;

	// Wishbone classic master request
	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic                    we;
		logic [WB_REQ_ADR_W-1:0] adr;
		logic [7:0]              dat;
	} wb_req_t;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////

	localparam logic [WB_REQ_ADR_W-1:0] ADDR_AUDIO_CTRL = 4'h0;

	// Audio control register with reserved bits reading as zero
	typedef struct packed {
		logic [2:0] rsvd;
		logic       synth_mute;
		logic [1:0] boost;
		logic [1:0] spk_vol;
	} audio_ctrl_t;

	// Boost 1 picks the 2x curve, 2 and 3 the 4x curve
	localparam logic [1:0] BOOST_OFF = 2'd0;

endpackage

`default_nettype wire

/* source/settle_capture.sv */
// Settle filter
`default_nettype none

module settle_capture #(
	parameter type payload_t = logic [31:0]
) (
	input  wire           clk_sys,
	input  wire           reset,
	input  wire payload_t din,
	output payload_t      dout
);

	payload_t stage0;
	payload_t stage1;

	// Two samples in a row must agree before the output moves
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stage0 <= '0;
			stage1 <= '0;
			dout   <= '0;
		end else begin
			stage0 <= din;
			stage1 <= stage0;
			if (stage0 == stage1) begin
				dout <= stage1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/mix_ctrl_regs.sv */
// Audio control register
`default_nettype none

module mix_ctrl_regs #(
	parameter int WB_ADDR_W = 4
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire ctrl_pkg::wb_req_t wb_req,
	output logic [7:0]             wb_dat_r,
	output logic                   wb_ack,
	output ctrl_pkg::audio_ctrl_t  ctrl
);

	logic [WB_ADDR_W-1:0]  adr;
	logic                  hit;
	logic                  take;
	ctrl_pkg::audio_ctrl_t wdata;

	logic [1:0] spk_vol_q;
	logic [1:0] boost_q;
	logic       mute_q;

	assign adr   = WB_ADDR_W'(wb_req.adr);
	assign hit   = (adr == WB_ADDR_W'(ctrl_pkg::ADDR_AUDIO_CTRL));
	assign take  = wb_req.cyc & wb_req.stb & ~wb_ack;
	assign wdata = ctrl_pkg::audio_ctrl_t'(wb_req.dat);

	// Ack lasts a single cycle and never comes twice in a row
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= take;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			spk_vol_q <= 2'd0;
			boost_q   <= 2'd0;
			mute_q    <= 1'b0;
		end else if (take && wb_req.we && hit) begin
			spk_vol_q <= wdata.spk_vol;
			boost_q   <= wdata.boost;
			mute_q    <= wdata.synth_mute;
		end
	end

	// Read data is valid while ack is high
	always_ff @(posedge clk_sys) begin
		if (take) begin
			wb_dat_r <= hit ? 8'(ctrl) : 8'h00;
		end
	end

	always_comb begin
		ctrl            = '0;
		ctrl.spk_vol    = spk_vol_q;
		ctrl.boost      = boost_q;
		ctrl.synth_mute = mute_q;
	end

endmodule

`default_nettype wire

/* source/channel_mixer.sv */
// Three source mixer
`default_nettype none

module channel_mixer (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire audio_pkg::stereo_t    sb,
	input  wire audio_pkg::stereo_t    synth,
	input  wire                        speaker,
	input  wire ctrl_pkg::audio_ctrl_t ctrl,
	output audio_pkg::stereo_t         mixed
);

	audio_pkg::wide_t   spk_term;
	audio_pkg::stereo_t synth_term;
	audio_pkg::wide_t   sum_l;
	audio_pkg::wide_t   sum_r;

	// Two full scale samples plus the loudest speaker step need a guard bit
	function automatic audio_pkg::wide_t sum3(input audio_pkg::sample_t a,
		input audio_pkg::sample_t b, input audio_pkg::wide_t c);
		logic signed [17:0] full;
		begin
			full = a + b + c;
			if (full[17] != full[16]) begin
				sum3 = full[17] ? 17'sh10000 : 17'sh0ffff;
			end else begin
				sum3 = full[16:0];
			end
		end
	endfunction

	function automatic audio_pkg::sample_t clamp16(input audio_pkg::wide_t w);
		if (w[16] != w[15]) begin
			clamp16 = w[16] ? 16'sh8000 : 16'sh7fff;
		end else begin
			clamp16 = w[15:0];
		end
	endfunction

	// Speaker weight doubles per volume step
	assign spk_term = speaker ?
		(audio_pkg::wide_t'(1) << (audio_pkg::SPK_BASE_SHIFT + ctrl.spk_vol)) : '0;

	assign synth_term = ctrl.synth_mute ? '0 : synth;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_l <= '0;
			sum_r <= '0;
			mixed <= '0;
		end else begin
			sum_l       <= sum3(sb.left, synth_term.left, spk_term);
			sum_r       <= sum3(sb.right, synth_term.right, spk_term);
			mixed.left  <= clamp16(sum_l);
			mixed.right <= clamp16(sum_r);
		end
	end

endmodule

`default_nettype wire

/* source/dyn_compressor.sv */
// Dynamic range compressor
`default_nettype none

module dyn_compressor (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire audio_pkg::stereo_t    din,
	input  wire ctrl_pkg::audio_ctrl_t ctrl,
	output audio_pkg::stereo_t         dout
);

	localparam logic [15:0] MAG_MAX = 16'h7fff;

	audio_pkg::stereo_t cmp;
	logic               use_4x;

	// Linear gain below the knee, shallow slope above it
	function automatic logic [15:0] curve(input logic [15:0] mag,
		input logic [15:0] knee, gain, fall, base);
		if (mag < knee) begin
			curve = mag * gain;
		end else begin
			curve = ((mag - knee) / fall) + base;
		end
	endfunction

	function automatic audio_pkg::sample_t compress(input audio_pkg::sample_t x,
		input logic sel_4x);
		logic [15:0] mag;
		logic [15:0] res;
		begin
			mag = x[15] ? (~x + 16'd1) : x;
			if (sel_4x) begin
				res = curve(mag, audio_pkg::CMP2_KNEE, audio_pkg::CMP2_GAIN,
					audio_pkg::CMP2_FALL, audio_pkg::CMP2_BASE);
			end else begin
				res = curve(mag, audio_pkg::CMP1_KNEE, audio_pkg::CMP1_GAIN,
					audio_pkg::CMP1_FALL, audio_pkg::CMP1_BASE);
			end
			// Top of both curves lands just past full scale
			if (res > MAG_MAX) begin
				res = MAG_MAX;
			end
			compress = x[15] ? audio_pkg::sample_t'(~res + 16'd1) : audio_pkg::sample_t'(res);
		end
	endfunction

	assign use_4x = ctrl.boost[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmp <= '0;
		end else begin
			cmp.left  <= compress(din.left, use_4x);
			cmp.right <= compress(din.right, use_4x);
		end
	end

	// Bypass skips the register
	assign dout = (ctrl.boost == ctrl_pkg::BOOST_OFF) ? din : cmp;

endmodule

`default_nettype wire

/* source/audio_out_stage.sv */
// Audio output stage
`default_nettype none

module audio_out_stage #(
	parameter int WB_ADDR_W = 4
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire ctrl_pkg::wb_req_t  wb_req,
	output logic [7:0]              wb_dat_r,
	output logic                    wb_ack,
	input  wire audio_pkg::stereo_t sb_in,
	input  wire audio_pkg::stereo_t synth_in,
	input  wire                     speaker,
	output audio_pkg::stereo_t      audio_out
);

	ctrl_pkg::audio_ctrl_t ctrl;
	audio_pkg::stereo_t    sb_settled;
	audio_pkg::stereo_t    synth_settled;
	audio_pkg::stereo_t    mixed;

	//////////////////////////////////////////////////////////////////////
	// Input filters
	//////////////////////////////////////////////////////////////////////

	settle_capture #(.payload_t(audio_pkg::stereo_t)) sb_settle (
		.clk_sys (clk_sys),
		.reset   (reset),
		.din     (sb_in),
		.dout    (sb_settled)
	);

	settle_capture #(.payload_t(audio_pkg::stereo_t)) synth_settle (
		.clk_sys (clk_sys),
		.reset   (reset),
		.din     (synth_in),
		.dout    (synth_settled)
	);

	mix_ctrl_regs #(.WB_ADDR_W(WB_ADDR_W)) ctrl_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wb_req   (wb_req),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.ctrl     (ctrl)
	);

	//////////////////////////////////////////////////////////////////////
	// Mix and compress
	//////////////////////////////////////////////////////////////////////

	channel_mixer mixer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sb      (sb_settled),
		.synth   (synth_settled),
		.speaker (speaker),
		.ctrl    (ctrl),
		.mixed   (mixed)
	);

	dyn_compressor compressor (
		.clk_sys (clk_sys),
		.reset   (reset),
		.din     (mixed),
		.ctrl    (ctrl),
		.dout    (audio_out)
	);

endmodule

`default_nettype wire

/* bench/audio_out_props.sv */
// Wishbone handshake assertions
`default_nettype none

module audio_out_props (
	input wire                    clk_sys,
	input wire                    reset,
	input wire ctrl_pkg::wb_req_t wb_req,
	input wire                    wb_ack
);

	int fail_count = 0;

	// Ack comes out of reset low
	ack_reset_low: assert property (@(posedge clk_sys) reset |=> !wb_ack)
		else begin
			fail_count++;
			$error("wb_ack high during or right after reset");
		end

	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |=> !wb_ack)
		else begin
			fail_count++;
			$error("wb_ack held for two cycles");
		end

	// Ack answers a request seen on the previous edge
	ack_after_req: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |-> $past(wb_req.cyc && wb_req.stb))
		else begin
			fail_count++;
			$error("wb_ack without cyc and stb");
		end

endmodule

`default_nettype wire

/* bench/audio_out_tb.sv */
// Audio output stage testbench
`default_nettype none

module audio_out_tb;

	logic               clk_sys;
	logic               reset;
	ctrl_pkg::wb_req_t  wb_req;
	logic [7:0]         wb_dat_r;
	logic               wb_ack;
	audio_pkg::stereo_t sb_in;
	audio_pkg::stereo_t synth_in;
	logic               speaker;
	audio_pkg::stereo_t audio_out;

	int         errors;
	integer     seed;
	logic [1:0] spk_vol;
	logic [1:0] boost;
	logic       mute;
	logic [7:0] rdata;

	audio_out_stage #(.WB_ADDR_W(4)) audio_out_stage_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.wb_req    (wb_req),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.sb_in     (sb_in),
		.synth_in  (synth_in),
		.speaker   (speaker),
		.audio_out (audio_out)
	);

	bind audio_out_stage audio_out_props props_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wb_req  (wb_req),
		.wb_ack  (wb_ack)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic int mix_sample(input int a, input int b, input logic spk);
		int sum;
		begin
			sum = a + (mute ? 0 : b);
			if (spk) begin
				sum = sum + (1 << (audio_pkg::SPK_BASE_SHIFT + spk_vol));
			end
			if (sum > 32767) sum = 32767;
			if (sum < -32768) sum = -32768;
			return sum;
		end
	endfunction

	function automatic int compress_sample(input int x);
		int knee;
		int gain;
		int fall;
		int base;
		int mag;
		int res;
		begin
			if (boost == 2'd0) return x;
			knee = (boost == 2'd1) ? audio_pkg::CMP1_KNEE : audio_pkg::CMP2_KNEE;
			gain = (boost == 2'd1) ? audio_pkg::CMP1_GAIN : audio_pkg::CMP2_GAIN;
			fall = (boost == 2'd1) ? audio_pkg::CMP1_FALL : audio_pkg::CMP2_FALL;
			base = (boost == 2'd1) ? audio_pkg::CMP1_BASE : audio_pkg::CMP2_BASE;
			mag = (x < 0) ? -x : x;
			res = (mag < knee) ? mag * gain : (mag - knee) / fall + base;
			// Curve tops out at full scale
			if (res > 32767) res = 32767;
			return (x < 0) ? -res : res;
		end
	endfunction

	function automatic audio_pkg::stereo_t expected_output(input audio_pkg::stereo_t sb,
		input audio_pkg::stereo_t syn, input logic spk);
		audio_pkg::stereo_t res;
		begin
			res.left  = 16'(compress_sample(mix_sample(sb.left, syn.left, spk)));
			res.right = 16'(compress_sample(mix_sample(sb.right, syn.right, spk)));
			return res;
		end
	endfunction

	function automatic audio_pkg::stereo_t make_pair(input int l, input int r);
		return {16'(l), 16'(r)};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Bus and stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			next_cycle();
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR time %0t: %s expected %h actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [7:0] dat,
		output logic [7:0] rd);
		int waited;
		begin
			wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
			waited = 0;
			rd = 8'h00;
			next_cycle();
			while (!wb_ack && waited < 20) begin
				next_cycle();
				waited++;
			end
			if (wb_ack) begin
				rd = wb_dat_r;
			end else begin
				errors++;
				$display("No ack arrived within 20 cycles for address %0d", adr);
			end
			wb_req = '0;
		end
	endtask

	task automatic set_ctrl(input logic [1:0] vol, input logic [1:0] bst, input logic mt);
		wb_access(1'b1, ctrl_pkg::ADDR_AUDIO_CTRL, {3'b000, mt, bst, vol}, rdata);
		spk_vol = vol;
		boost   = bst;
		mute    = mt;
	endtask

	// Inputs stay put long enough for the whole pipeline to settle
	task automatic run_case(input audio_pkg::stereo_t sb, input audio_pkg::stereo_t syn,
		input logic spk);
		sb_in    = sb;
		synth_in = syn;
		speaker  = spk;
		wait_cycles(8);
		check("audio_out", expected_output(sb, syn, spk), audio_out);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int                 knee;
		audio_pkg::stereo_t held;
		errors   = 0;
		seed     = 36;
		spk_vol  = 2'd0;
		boost    = 2'd0;
		mute     = 1'b0;
		reset    = 1'b1;
		wb_req   = '0;
		sb_in    = '0;
		synth_in = '0;
		speaker  = 1'b0;
		wait_cycles(3);
		reset = 1'b0;
		check("audio_out", 32'h0, audio_out);

		wb_access(1'b0, ctrl_pkg::ADDR_AUDIO_CTRL, 8'h00, rdata);
		check("wb_dat_r", 8'h00, rdata);

		// Reserved bits drop and an unmapped address is ignored
		wb_access(1'b1, ctrl_pkg::ADDR_AUDIO_CTRL, 8'hff, rdata);
		wb_access(1'b0, ctrl_pkg::ADDR_AUDIO_CTRL, 8'h00, rdata);
		check("wb_dat_r", 8'h1f, rdata);
		wb_access(1'b1, 4'd5, 8'h00, rdata);
		wb_access(1'b0, ctrl_pkg::ADDR_AUDIO_CTRL, 8'h00, rdata);
		check("wb_dat_r", 8'h1f, rdata);
		wb_access(1'b0, 4'd5, 8'h00, rdata);
		check("wb_dat_r", 8'h00, rdata);

		for (int v = 0; v < 4; v++) begin
			set_ctrl(2'(v), 2'd0, 1'b0);
			for (int n = 0; n < 6; n++) begin
				run_case(32'($random(seed)), 32'($random(seed)), 1'($random(seed)));
			end
		end
		// Overflow both ways at the loudest speaker step
		run_case(make_pair(30000, -30000), make_pair(20000, -20000), 1'b1);
		run_case(make_pair(-25000, 25000), make_pair(-25000, 25000), 1'b0);

		set_ctrl(2'd1, 2'd0, 1'b1);
		run_case(make_pair(1000, -2000), make_pair(5000, 7000), 1'b1);
		set_ctrl(2'd1, 2'd0, 1'b0);
		run_case(make_pair(1000, -2000), make_pair(5000, 7000), 1'b1);

		for (int b = 1; b < 4; b += 2) begin
			set_ctrl(2'd0, 2'(b), 1'b0);
			knee = (b == 1) ? audio_pkg::CMP1_KNEE : audio_pkg::CMP2_KNEE;
			run_case(make_pair(knee - 1, -(knee - 1)), '0, 1'b0);
			run_case(make_pair(knee, -knee), '0, 1'b0);
			run_case(make_pair(knee + 999, -(knee + 999)), '0, 1'b0);
			run_case(make_pair(32767, -32768), '0, 1'b0);
		end

		// A toggling input never settles, so the output holds
		set_ctrl(2'd2, 2'd0, 1'b0);
		run_case(make_pair(1200, -800), make_pair(300, 300), 1'b1);
		held = expected_output(make_pair(1200, -800), make_pair(300, 300), 1'b1);
		for (int n = 0; n < 12; n++) begin
			sb_in = n[0] ? make_pair(-9000, 4000) : make_pair(7000, 6000);
			next_cycle();
			check("audio_out", held, audio_out);
		end
		run_case(make_pair(-9000, 4000), make_pair(300, 300), 1'b1);

		errors += audio_out_stage_i.props_i.fail_count;
		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
source/audio_pkg.sv
source/ctrl_pkg.sv
source/settle_capture.sv
source/mix_ctrl_regs.sv
source/channel_mixer.sv
source/dyn_compressor.sv
source/audio_out_stage.sv
bench/audio_out_props.sv
bench/audio_out_tb.sv
